//--- rtl/dir_pkg.sv
package dir_pkg;

   // Cluster shape
   localparam int num_cores = 4;
   localparam int num_ways = 8;

   localparam int core_id_w = $clog2(num_cores);
   localparam int way_id_w = $clog2(num_ways);

   typedef logic [core_id_w-1:0] core_id_t;

   // One bit per core, nonzero means the way is valid
   typedef logic [num_cores-1:0] presence_t;

   typedef enum logic [2:0] {
      op_read     = 3'd0, // Add source to sharers
      op_write    = 3'd1, // Source becomes sole owner
      op_evict    = 3'd2, // Drop source
      op_transfer = 3'd3, // Move line from source to dest
      op_flush    = 3'd4  // Drop everyone
   } dir_op_e;

endpackage

//--- rtl/dir_req_arbiter.sv
module dir_req_arbiter #(
   parameter int TAG_SIZE = 18,
   parameter int NUM_SETS = 4,
   localparam int idx_w = (NUM_SETS > 1) ? $clog2(NUM_SETS) : 1
) (
   input  logic                      clk,
   input  logic                      arst_n,

   input  logic [dir_pkg::num_cores-1:0] req_valid,
   input  logic [TAG_SIZE-1:0]           req_tag [dir_pkg::num_cores],
   input  logic [idx_w-1:0]              req_index [dir_pkg::num_cores],
   input  dir_pkg::dir_op_e              req_op [dir_pkg::num_cores],
   input  dir_pkg::core_id_t             req_dest [dir_pkg::num_cores],
   output logic [dir_pkg::num_cores-1:0] req_ready,

   output logic                      s1_valid,
   output dir_pkg::core_id_t         s1_core,
   output logic [TAG_SIZE-1:0]       s1_tag,
   output logic [idx_w-1:0]          s1_index,
   output dir_pkg::dir_op_e          s1_op,
   output dir_pkg::core_id_t         s1_dest
);

   import dir_pkg::*;

   core_id_t last_q;       // Last granted core
   core_id_t grant_core;
   logic     grant_found;

   // Search starts one past the last grant
   always_comb begin
      core_id_t cand;
      grant_found = 1'b0;
      grant_core = last_q;
      for (int k = 1; k <= num_cores; k++) begin
         cand = core_id_t'(last_q + k);
         if (!grant_found && req_valid[cand]) begin
            grant_found = 1'b1;
            grant_core = cand;
         end
      end
   end

   always_comb begin
      for (int i = 0; i < num_cores; i++) begin
         req_ready[i] = grant_found && (grant_core == core_id_t'(i));
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         last_q <= core_id_t'(num_cores - 1); // Core 0 first after reset
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= grant_found;
         if (grant_found) begin
            last_q <= grant_core;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (grant_found) begin
         s1_core <= grant_core;
         s1_tag <= req_tag[grant_core];
         s1_index <= req_index[grant_core];
         s1_op <= req_op[grant_core];
         s1_dest <= req_dest[grant_core];
      end
   end

endmodule

//--- rtl/dir_way_select.sv
module dir_way_select #(
   parameter int TAG_SIZE = 18
) (
   input  logic                  s1_valid,
   input  logic [TAG_SIZE-1:0]   tag_in,
   input  logic [TAG_SIZE-1:0]   set_tags [dir_pkg::num_ways],
   input  dir_pkg::presence_t    set_presence [dir_pkg::num_ways],
   input  dir_pkg::presence_t    next_presence,

   output dir_pkg::presence_t    selected_presence,
   output logic                  hit,
   output logic                  full,
   output logic [TAG_SIZE-1:0]   next_tags [dir_pkg::num_ways],
   output dir_pkg::presence_t    next_set_presence [dir_pkg::num_ways],
   output logic                  wr_en
);

   import dir_pkg::*;

   logic [num_ways-1:0] valid_ways;
   logic [num_ways-1:0] match_ways;
   logic [way_id_w-1:0] hit_way;
   logic [way_id_w-1:0] victim_way;
   logic                victim_found;
   logic                alloc;

   always_comb begin
      for (int w = 0; w < num_ways; w++) begin
         valid_ways[w] = |set_presence[w];
         match_ways[w] = valid_ways[w] && (set_tags[w] == tag_in);
      end
   end

   // Highest matching way wins
   always_comb begin
      hit_way = '0;
      for (int w = 0; w < num_ways; w++) begin
         if (match_ways[w]) begin
            hit_way = w[way_id_w-1:0];
         end
      end
   end

   // Lowest free way
   always_comb begin
      victim_way = '0;
      for (int w = num_ways - 1; w >= 0; w--) begin
         if (!valid_ways[w]) begin
            victim_way = w[way_id_w-1:0];
         end
      end
   end

   assign hit = |match_ways;
   assign victim_found = ~&valid_ways;
   assign selected_presence = hit ? set_presence[hit_way] : '0;

   // Only read and write produce a nonzero vector on a miss
   assign alloc = !hit && (|next_presence);
   assign full = alloc && !victim_found;

   always_comb begin
      next_tags = set_tags;
      next_set_presence = set_presence;
      if (hit) begin
         next_set_presence[hit_way] = next_presence;
      end else if (alloc && victim_found) begin
         next_tags[victim_way] = tag_in;
         next_set_presence[victim_way] = next_presence;
      end
   end

   assign wr_en = s1_valid && (hit || (alloc && victim_found));

endmodule

//--- rtl/dir_next_state.sv
module dir_next_state (
   input  dir_pkg::dir_op_e   op,
   input  dir_pkg::core_id_t  src,
   input  dir_pkg::core_id_t  dest,
   input  dir_pkg::presence_t current_presence,
   output dir_pkg::presence_t next_presence,
   output dir_pkg::presence_t inval
);

   import dir_pkg::*;

   presence_t src_bit;
   presence_t dest_bit;
   logic      present;

   assign src_bit = presence_t'(1) << src;
   assign dest_bit = presence_t'(1) << dest;

   // Zero vector here means the line missed
   assign present = |current_presence;

   always_comb begin
      next_presence = current_presence;
      inval = '0;
      case (op)
         op_read: begin
            next_presence = current_presence | src_bit;
         end
         op_write: begin
            next_presence = src_bit;
            inval = current_presence & ~src_bit; // Everyone else loses it
         end
         op_evict: begin
            next_presence = current_presence & ~src_bit;
         end
         op_transfer: begin
            // No line to move on a miss
            if (present) begin
               next_presence = (current_presence & ~src_bit) | dest_bit;
            end else begin
               next_presence = '0;
            end
         end
         op_flush: begin
            next_presence = '0;
         end
         default: begin
            next_presence = current_presence;
         end
      endcase
   end

endmodule

//--- rtl/dir_set_store.sv
module dir_set_store #(
   parameter int TAG_SIZE = 18,
   parameter int NUM_SETS = 4,
   localparam int idx_w = (NUM_SETS > 1) ? $clog2(NUM_SETS) : 1
) (
   input  logic                clk,
   input  logic                arst_n,

   input  logic [idx_w-1:0]    rd_index,
   output logic [TAG_SIZE-1:0] set_tags [dir_pkg::num_ways],
   output dir_pkg::presence_t  set_presence [dir_pkg::num_ways],

   input  logic                wr_en,
   input  logic [idx_w-1:0]    wr_index,
   input  logic [TAG_SIZE-1:0] wr_tags [dir_pkg::num_ways],
   input  dir_pkg::presence_t  wr_presence [dir_pkg::num_ways]
);

   import dir_pkg::*;

   logic [TAG_SIZE-1:0] tags_q [NUM_SETS][num_ways];
   presence_t           presence_q [NUM_SETS][num_ways];

   // Whole set visible in the same cycle
   assign set_tags = tags_q[rd_index];
   assign set_presence = presence_q[rd_index];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < num_ways; w++) begin
               presence_q[s][w] <= '0;
            end
         end
      end else if (wr_en) begin
         presence_q[wr_index] <= wr_presence;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         tags_q[wr_index] <= wr_tags;
      end
   end

endmodule

//--- rtl/dir_top.sv
module dir_top #(
   parameter int TAG_SIZE = 18,
   parameter int NUM_SETS = 4,
   localparam int idx_w = (NUM_SETS > 1) ? $clog2(NUM_SETS) : 1
) (
   input  logic                          clk,
   input  logic                          arst_n,

   input  logic [dir_pkg::num_cores-1:0] req_valid,
   input  logic [TAG_SIZE-1:0]           req_tag [dir_pkg::num_cores],
   input  logic [idx_w-1:0]              req_index [dir_pkg::num_cores],
   input  dir_pkg::dir_op_e              req_op [dir_pkg::num_cores],
   input  dir_pkg::core_id_t             req_dest [dir_pkg::num_cores],
   output logic [dir_pkg::num_cores-1:0] req_ready,

   output logic [dir_pkg::num_cores-1:0] rsp_valid,
   output logic                          rsp_hit,
   output logic                          rsp_full,
   output dir_pkg::presence_t            rsp_sharers,
   output dir_pkg::presence_t            rsp_inval
);

   import dir_pkg::*;

   logic                s1_valid;
   core_id_t            s1_core;
   logic [TAG_SIZE-1:0] s1_tag;
   logic [idx_w-1:0]    s1_index;
   dir_op_e             s1_op;
   core_id_t            s1_dest;

   logic [TAG_SIZE-1:0] set_tags [num_ways];
   presence_t           set_presence [num_ways];
   logic [TAG_SIZE-1:0] next_tags [num_ways];
   presence_t           next_set_presence [num_ways];

   presence_t selected_presence;
   presence_t next_presence;
   presence_t inval;
   logic      hit;
   logic      full;
   logic      wr_en;

   dir_req_arbiter #(.TAG_SIZE(TAG_SIZE), .NUM_SETS(NUM_SETS)) u_arbiter (
      .clk, .arst_n,
      .req_valid, .req_tag, .req_index, .req_op, .req_dest, .req_ready,
      .s1_valid, .s1_core, .s1_tag, .s1_index, .s1_op, .s1_dest
   );

   dir_set_store #(.TAG_SIZE(TAG_SIZE), .NUM_SETS(NUM_SETS)) u_store (
      .clk, .arst_n,
      .rd_index(s1_index), .set_tags, .set_presence,
      .wr_en, .wr_index(s1_index), .wr_tags(next_tags), .wr_presence(next_set_presence)
   );

   dir_way_select #(.TAG_SIZE(TAG_SIZE)) u_way_select (
      .s1_valid, .tag_in(s1_tag), .set_tags, .set_presence, .next_presence,
      .selected_presence, .hit, .full, .next_tags, .next_set_presence, .wr_en
   );

   dir_next_state u_next_state (
      .op(s1_op), .src(s1_core), .dest(s1_dest),
      .current_presence(selected_presence), .next_presence, .inval
   );

   // Response stage, one pulse per granted request
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rsp_valid <= '0;
      end else begin
         rsp_valid <= s1_valid ? (presence_t'(1) << s1_core) : '0;
      end
   end

   always_ff @(posedge clk) begin
      if (s1_valid) begin
         rsp_hit <= hit;
         rsp_full <= full;
         rsp_sharers <= selected_presence; // Vector before the op
         rsp_inval <= inval;
      end
   end

endmodule

//--- verif/dir_checker.sv
module dir_checker #(
   parameter int TAG_SIZE = 18,
   parameter int NUM_SETS = 4,
   localparam int idx_w = (NUM_SETS > 1) ? $clog2(NUM_SETS) : 1
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic [dir_pkg::num_cores-1:0] req_valid,
   input  logic [TAG_SIZE-1:0]           req_tag [dir_pkg::num_cores],
   input  logic [idx_w-1:0]              req_index [dir_pkg::num_cores],
   input  dir_pkg::dir_op_e              req_op [dir_pkg::num_cores],
   input  dir_pkg::core_id_t             req_dest [dir_pkg::num_cores],
   input  logic [dir_pkg::num_cores-1:0] req_ready,
   input  logic [dir_pkg::num_cores-1:0] rsp_valid,
   input  logic                          rsp_hit,
   input  logic                          rsp_full,
   input  dir_pkg::presence_t            rsp_sharers,
   input  dir_pkg::presence_t            rsp_inval,
   output int                            errors,
   output int                            checked,
   output int                            pending
);
   timeunit 1ns;
   timeprecision 1ps;

   import dir_pkg::*;

   logic [TAG_SIZE-1:0] m_tags [NUM_SETS][num_ways];
   presence_t           m_pres [NUM_SETS][num_ways];
   int                  last_grant;
   int                  cyc;

   // Expected responses in transfer order
   int        q_core [$];
   int        q_cyc [$];
   logic      q_hit [$];
   logic      q_full [$];
   presence_t q_sh [$];
   presence_t q_inv [$];

   int        c, w, hw, vw, exp_core;
   presence_t cur, nxt, inv, sbit, dbit;
   logic      h, f;

   assign pending = q_core.size();

   task automatic compare(input string name, input int exp, input int got);
      if (exp != got) begin
         $display("FAIL t=%0t %s expected %0h got %0h", $time, name, exp, got);
         errors++;
      end
   endtask

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int s = 0; s < NUM_SETS; s++) begin
            for (int k = 0; k < num_ways; k++) m_pres[s][k] = '0;
         end
         last_grant = num_cores - 1;
         cyc = 0;
      end else begin
         exp_core = -1;
         for (int k = 1; k <= num_cores; k++) begin
            if (exp_core < 0 && req_valid[(last_grant + k) % num_cores]) begin
               exp_core = (last_grant + k) % num_cores;
            end
         end
         // One-hot ready for the round-robin winner only
         compare("req_ready", (exp_core >= 0) ? (1 << exp_core) : 0, req_ready);
         for (c = 0; c < num_cores; c++) begin
            if (req_valid[c] && req_ready[c]) begin
               last_grant = c;
               hw = -1;
               vw = -1;
               for (w = 0; w < num_ways; w++) begin
                  if (m_pres[req_index[c]][w] != 0 && m_tags[req_index[c]][w] == req_tag[c])
                     hw = w; // Highest hit
               end
               for (w = num_ways - 1; w >= 0; w--) begin
                  if (m_pres[req_index[c]][w] == 0) vw = w; // Lowest free
               end
               h = (hw >= 0);
               cur = h ? m_pres[req_index[c]][hw] : '0;
               sbit = presence_t'(1 << c);
               dbit = presence_t'(1 << req_dest[c]);
               inv = '0;
               case (req_op[c])
                  op_read: nxt = cur | sbit;
                  op_write: begin
                     nxt = sbit;
                     inv = cur & ~sbit;
                  end
                  op_evict: nxt = cur & ~sbit;
                  op_transfer: nxt = h ? ((cur & ~sbit) | dbit) : '0;
                  default: nxt = '0;
               endcase
               f = !h && (req_op[c] == op_read || req_op[c] == op_write) && vw < 0;
               if (h) begin
                  m_pres[req_index[c]][hw] = nxt;
               end else if ((req_op[c] == op_read || req_op[c] == op_write) && !f) begin
                  m_tags[req_index[c]][vw] = req_tag[c];
                  m_pres[req_index[c]][vw] = nxt;
               end
               q_core.push_back(c);
               q_cyc.push_back(cyc);
               q_hit.push_back(h);
               q_full.push_back(f);
               q_sh.push_back(cur);
               q_inv.push_back(inv);
            end
         end
         cyc++;
      end
   end

   // Responses are stable at the falling edge
   always @(negedge clk) begin
      if (arst_n && q_core.size() > 0) begin
         if (rsp_valid != 0) begin
            compare("rsp_valid", 1 << q_core[0], rsp_valid);
            compare("rsp_latency", q_cyc[0] + 2, cyc);
            compare("rsp_hit", q_hit[0], rsp_hit);
            compare("rsp_full", q_full[0], rsp_full);
            compare("rsp_sharers", q_sh[0], rsp_sharers);
            compare("rsp_inval", q_inv[0], rsp_inval);
            $display("response core %0d hit %0b full %0b sharers %b inval %b", q_core[0],
                     rsp_hit, rsp_full, rsp_sharers, rsp_inval);
            checked++;
            void'(q_core.pop_front());
            void'(q_cyc.pop_front());
            void'(q_hit.pop_front());
            void'(q_full.pop_front());
            void'(q_sh.pop_front());
            void'(q_inv.pop_front());
         end else if (cyc > q_cyc[0] + 2) begin
            $display("Response for core %0d did not arrive in time", q_core[0]);
            errors++;
            void'(q_core.pop_front());
            void'(q_cyc.pop_front());
            void'(q_hit.pop_front());
            void'(q_full.pop_front());
            void'(q_sh.pop_front());
            void'(q_inv.pop_front());
         end
      end else if (arst_n && rsp_valid != 0) begin
         $display("Response seen with no request outstanding");
         errors++;
      end
   end

   initial begin
      errors = 0;
      checked = 0;
   end

endmodule

//--- verif/dir_tb.sv
module dir_tb;
   timeunit 1ns;
   timeprecision 1ps;

   import dir_pkg::*;

   localparam int TAG_SIZE = 18;
   localparam int NUM_SETS = 4;
   localparam int idx_w = (NUM_SETS > 1) ? $clog2(NUM_SETS) : 1;
   localparam int max_entries = 40;

   logic                clk;
   logic                arst_n;
   logic [num_cores-1:0] req_valid;
   logic [TAG_SIZE-1:0] req_tag [num_cores];
   logic [idx_w-1:0]    req_index [num_cores];
   dir_op_e             req_op [num_cores];
   core_id_t            req_dest [num_cores];
   logic [num_cores-1:0] req_ready;
   logic [num_cores-1:0] rsp_valid;
   logic                rsp_hit;
   logic                rsp_full;
   presence_t           rsp_sharers;
   presence_t           rsp_inval;
   int                  errors;
   int                  checked;
   int                  pending;

   // Stimulus table, entries sharing a step are driven together
   int      t_step [max_entries];
   int      t_core [max_entries];
   dir_op_e t_op [max_entries];
   int      t_index [max_entries];
   int      t_tag [max_entries];
   int      t_dest [max_entries];
   int      n_entries;
   int      seed;
   int      failures;

   dir_top #(.TAG_SIZE(TAG_SIZE), .NUM_SETS(NUM_SETS)) dut (.*);

   dir_checker #(.TAG_SIZE(TAG_SIZE), .NUM_SETS(NUM_SETS)) u_checker (.*);

   always #4 clk = ~clk;

   task automatic add_entry(input int step, input int core, input dir_op_e op,
                            input int index, input int tag, input int dest);
      t_step[n_entries] = step;
      t_core[n_entries] = core;
      t_op[n_entries] = op;
      t_index[n_entries] = index;
      t_tag[n_entries] = tag;
      t_dest[n_entries] = dest;
      n_entries++;
   endtask

   task automatic build_table();
      n_entries = 0;
      add_entry(0, 0, op_read, 0, 'h0a, 0); // Miss allocates
      add_entry(1, 1, op_read, 0, 'h0a, 0);
      add_entry(2, 2, op_read, 0, 'h0a, 0);
      add_entry(3, 3, op_write, 0, 'h0a, 0); // Invalidates 0..2
      add_entry(4, 3, op_transfer, 0, 'h0a, 1);
      add_entry(5, 0, op_read, 0, 'h0a, 0);
      add_entry(6, 1, op_evict, 0, 'h0a, 0);
      add_entry(7, 0, op_flush, 0, 'h0a, 0);
      add_entry(8, 2, op_read, 0, 'h0b, 0); // Reuses way 0
      for (int k = 0; k < 9; k++) begin
         add_entry(9 + k, k % num_cores, op_read, 1, 'h100 + k, 0);
      end
      add_entry(18, 0, op_read, 1, 'h100, 0);
      add_entry(19, 1, op_read, 1, 'h108, 0); // Still full
      for (int k = 0; k < num_cores; k++) begin
         add_entry(20, k, op_read, 2, 'h200 + k, 0);
      end
      add_entry(21, 1, op_write, 3, 'h300, 0);
      add_entry(21, 2, op_write, 3, 'h300, 0);
      add_entry(22, 2, op_read, 2, 'h2f0, 0);
      add_entry(22, 3, op_write, 2, 'h2f0, 0);
      add_entry(23, 0, op_transfer, 3, 'h3ff, 1); // Miss, no change
      add_entry(24, 0, op_read, 3, 'h300, 0);
      add_entry(25, 1, op_flush, 1, 'h103, 0);
      add_entry(26, 2, op_read, 1, 'h108, 0); // Takes the freed way
      add_entry(27, 3, op_read, 1, 'h109, 0);
   endtask

   task automatic run_step(input int first, input int last);
      int order [$];
      int tmp;
      int timeout;
      for (int e = first; e <= last; e++) order.push_back(e);
      if (order.size() > 1 && ($random(seed) & 1)) begin
         tmp = order[0];
         order[0] = order[1];
         order[1] = tmp;
      end
      foreach (order[k]) begin
         req_tag[t_core[order[k]]] = TAG_SIZE'(t_tag[order[k]]);
         req_index[t_core[order[k]]] = idx_w'(t_index[order[k]]);
         req_op[t_core[order[k]]] = t_op[order[k]];
         req_dest[t_core[order[k]]] = core_id_t'(t_dest[order[k]]);
         req_valid[t_core[order[k]]] = 1'b1;
      end
      timeout = 0;
      while (req_valid != 0 && timeout < 20) begin
         #1;
         tmp = req_valid & req_ready;
         @(posedge clk);
         @(negedge clk);
         req_valid = req_valid & ~tmp[num_cores-1:0];
         timeout++;
      end
      if (req_valid != 0) begin
         $display("Request from cores %b was never accepted", req_valid);
         failures++;
         req_valid = '0;
      end
   endtask

   initial begin
      int first;
      int timeout;
      clk = 1'b0;
      arst_n = 1'b0;
      req_valid = '0;
      for (int c = 0; c < num_cores; c++) begin
         req_tag[c] = '0;
         req_index[c] = '0;
         req_op[c] = op_read;
         req_dest[c] = '0;
      end
      seed = 32'hf9ad;
      failures = 0;
      build_table();
      repeat (5) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      first = 0;
      while (first < n_entries) begin
         int last;
         last = first;
         while (last + 1 < n_entries && t_step[last + 1] == t_step[first]) last++;
         run_step(first, last);
         first = last + 1;
      end
      timeout = 0;
      while (pending != 0 && timeout < 20) begin
         @(negedge clk);
         timeout++;
      end
      @(negedge clk);
      if (pending != 0) begin
         $display("Responses still outstanding at the end of the run");
         failures++;
      end
      $display("Checked %0d responses, %0d errors", checked, errors + failures);
      if (errors == 0 && failures == 0 && checked == n_entries) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- all.f
rtl/dir_pkg.sv
rtl/dir_req_arbiter.sv
rtl/dir_way_select.sv
rtl/dir_next_state.sv
rtl/dir_set_store.sv
rtl/dir_top.sv
verif/dir_checker.sv
verif/dir_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wall -Wno-fatal
TOP       ?= dir_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module dir_top -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
